//--- logic/cp0_pkg.sv
package cp0_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] exc_type_t;
	typedef logic [4:0] exc_code_t;

	// cp0 register numbers
	localparam reg_addr_t CP0_BADVADDR = 5'd8;
	localparam reg_addr_t CP0_COUNT = 5'd9;
	localparam reg_addr_t CP0_COMPARE = 5'd11;
	localparam reg_addr_t CP0_STATUS = 5'd12;
	localparam reg_addr_t CP0_CAUSE = 5'd13;
	localparam reg_addr_t CP0_EPC = 5'd14;
	localparam reg_addr_t CP0_PRID = 5'd15;
	localparam reg_addr_t CP0_CONFIG = 5'd16;

	// exception type words from the pipeline
	localparam exc_type_t EXT_INT = 32'h0000_0001;
	localparam exc_type_t EXT_ADEL = 32'h0000_0004;
	localparam exc_type_t EXT_ADES = 32'h0000_0005;
	localparam exc_type_t EXT_SYS = 32'h0000_0008;
	localparam exc_type_t EXT_BP = 32'h0000_0009;
	localparam exc_type_t EXT_RI = 32'h0000_000a;
	localparam exc_type_t EXT_OV = 32'h0000_000c;
	localparam exc_type_t EXT_TR = 32'h0000_000d;
	localparam exc_type_t EXT_ERET = 32'h0000_000e;

	// cause.exccode values
	localparam exc_code_t EXC_INT = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS = 5'd8;
	localparam exc_code_t EXC_BP = 5'd9;
	localparam exc_code_t EXC_RI = 5'd10;
	localparam exc_code_t EXC_OV = 5'd12;
	localparam exc_code_t EXC_TR = 5'd13;

	localparam word_t STATUS_RST = 32'h0040_0000; // bev set
	localparam word_t CONFIG_RST = 32'h0000_8000;
	localparam word_t PRID_VAL = 32'h004c_0102;

	localparam int STATUS_EXL = 1;
	localparam int CAUSE_BD = 31;
	localparam int CAUSE_IV = 23;
	localparam int CAUSE_WP = 22;
	localparam int CAUSE_SW1 = 9; // software interrupt bits
	localparam int CAUSE_SW0 = 8;
	localparam int CAUSE_IP_HI = 15; // hardware interrupt pending
	localparam int CAUSE_IP_LO = 10;
	localparam int CAUSE_EXC_HI = 6;
	localparam int CAUSE_EXC_LO = 2;

	// bits of cause that mtc0 may change
	localparam word_t CAUSE_WMASK = (word_t'(1) << CAUSE_IV)
		| (word_t'(1) << CAUSE_WP)
		| (word_t'(1) << CAUSE_SW1)
		| (word_t'(1) << CAUSE_SW0);

endpackage

//--- logic/cp0_except_arb.sv
`timescale 1ns/100ps

module cp0_except_arb (
	input cp0_pkg::exc_type_t exc_type1_i,
	input cp0_pkg::exc_type_t exc_type2_i,
	input cp0_pkg::word_t inst_addr1_i,
	input cp0_pkg::word_t inst_addr2_i,
	input logic in_dslot1_i,
	input logic in_dslot2_i,
	input cp0_pkg::word_t bad_addr1_i,
	input cp0_pkg::word_t bad_addr2_i,
	output logic exc_valid_o,
	output logic exc_eret_o,
	output cp0_pkg::exc_code_t exc_code_o,
	output cp0_pkg::word_t exc_epc_o,
	output logic exc_bd_o,
	output logic exc_badv_we_o,
	output cp0_pkg::word_t exc_badvaddr_o
);
	import cp0_pkg::*;

	logic taken1;
	logic taken2;
	logic eret1;
	logic eret2;
	exc_code_t code1;
	exc_code_t code2;
	logic sel1;
	word_t sel_addr;
	word_t sel_bad;
	logic sel_dslot;

	function automatic void decode_type(
		input exc_type_t t,
		output logic taken,
		output logic eret,
		output exc_code_t code
	);
		taken = 1'b1;
		eret = 1'b0;
		code = EXC_INT;
		case (t)
			EXT_INT: code = EXC_INT;
			EXT_ADEL: code = EXC_ADEL;
			EXT_ADES: code = EXC_ADES;
			EXT_SYS: code = EXC_SYS;
			EXT_BP: code = EXC_BP;
			EXT_RI: code = EXC_RI;
			EXT_OV: code = EXC_OV;
			EXT_TR: code = EXC_TR;
			EXT_ERET: begin
				taken = 1'b0;
				eret = 1'b1;
			end
			default: taken = 1'b0; // no event
		endcase
	endfunction

	always_comb begin
		decode_type(exc_type1_i, taken1, eret1, code1);
		decode_type(exc_type2_i, taken2, eret2, code2);
	end

	assign sel1 = taken1 | eret1; // lane 1 has priority

	assign exc_valid_o = sel1 ? taken1 : taken2;
	assign exc_eret_o = sel1 ? eret1 : eret2;
	assign exc_code_o = sel1 ? code1 : code2;

	assign sel_addr = sel1 ? inst_addr1_i : inst_addr2_i;
	assign sel_dslot = sel1 ? in_dslot1_i : in_dslot2_i;
	assign sel_bad = sel1 ? bad_addr1_i : bad_addr2_i;

	// epc points at the branch for a delay-slot instruction
	assign exc_epc_o = sel_dslot ? sel_addr - 32'd4 : sel_addr;
	assign exc_bd_o = sel_dslot;

	assign exc_badv_we_o = exc_valid_o
		&& (exc_code_o == EXC_ADEL || exc_code_o == EXC_ADES);
	assign exc_badvaddr_o = exc_badv_we_o ? sel_bad : '0;

endmodule

//--- logic/cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer (
	input logic clk,
	input logic rst_n_i,
	input logic upd_i,
	input logic count_we_i,
	input logic compare_we_i,
	input cp0_pkg::word_t wdata_i,
	output cp0_pkg::word_t count_o,
	output cp0_pkg::word_t compare_o,
	output logic timer_int_o
);
	import cp0_pkg::*;

	logic [32:0] count_q; // bit 0 halves the rate
	word_t compare_q;
	logic int_q;
	logic match;

	assign count_o = count_q[32:1];
	assign compare_o = compare_q;
	assign timer_int_o = int_q;

	assign match = (compare_q != '0) && (count_o == compare_q);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count_q <= '0;
			compare_q <= '0;
			int_q <= 1'b0;
		end else if (upd_i) begin
			if (count_we_i) begin
				count_q <= {wdata_i, ~count_q[0]}; // half bit keeps running
			end else begin
				count_q <= count_q + 33'd1;
			end
			if (compare_we_i) begin
				compare_q <= wdata_i;
				int_q <= 1'b0; // ack by rewriting compare
			end else if (match) begin
				int_q <= 1'b1;
			end
		end
	end

endmodule

//--- logic/cp0_reg.sv
`timescale 1ns/100ps

module cp0_reg (
	input logic clk,
	input logic rst_n_i,
	input logic stall_i,
	input logic we1_i,
	input logic we2_i,
	input cp0_pkg::reg_addr_t waddr1_i,
	input cp0_pkg::reg_addr_t waddr2_i,
	input cp0_pkg::word_t wdata1_i,
	input cp0_pkg::word_t wdata2_i,
	input cp0_pkg::reg_addr_t raddr1_i,
	input cp0_pkg::reg_addr_t raddr2_i,
	input logic [5:0] int_i,
	input logic exc_valid_i,
	input logic exc_eret_i,
	input cp0_pkg::exc_code_t exc_code_i,
	input cp0_pkg::word_t exc_epc_i,
	input logic exc_bd_i,
	input logic exc_badv_we_i,
	input cp0_pkg::word_t exc_badvaddr_i,
	output cp0_pkg::word_t status_o,
	output cp0_pkg::word_t cause_o,
	output cp0_pkg::word_t epc_o,
	output cp0_pkg::word_t rdata1_o,
	output cp0_pkg::word_t rdata2_o,
	output cp0_pkg::word_t count_o,
	output logic timer_int_o
);
	import cp0_pkg::*;

	logic upd;
	logic we;
	reg_addr_t waddr;
	word_t wdata;
	logic count_we;
	logic compare_we;
	logic status_we;
	logic cause_we;
	logic epc_we;
	word_t status_q;
	word_t cause_q;
	word_t epc_q;
	word_t badvaddr_q;
	word_t count;
	word_t compare;

	// a stalled mtc0 holds the whole block
	assign upd = ~(stall_i & (we1_i | we2_i));

	assign we = we1_i | we2_i;
	assign waddr = we2_i ? waddr2_i : waddr1_i; // lane 2 wins
	assign wdata = we2_i ? wdata2_i : wdata1_i;

	assign count_we = we && (waddr == CP0_COUNT);
	assign compare_we = we && (waddr == CP0_COMPARE);
	assign status_we = we && (waddr == CP0_STATUS);
	assign cause_we = we && (waddr == CP0_CAUSE);
	assign epc_we = we && (waddr == CP0_EPC);

	cp0_timer u_timer (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.upd_i(upd),
		.count_we_i(count_we),
		.compare_we_i(compare_we),
		.wdata_i(wdata),
		.count_o(count),
		.compare_o(compare),
		.timer_int_o(timer_int_o)
	);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			status_q <= STATUS_RST;
			cause_q <= '0;
			epc_q <= '0;
			badvaddr_q <= '0;
		end else if (upd) begin
			if (status_we) begin
				status_q <= wdata;
			end
			if (cause_we) begin
				cause_q <= (cause_q & ~CAUSE_WMASK) | (wdata & CAUSE_WMASK);
			end
			if (epc_we) begin
				epc_q <= wdata;
			end
			cause_q[CAUSE_IP_HI:CAUSE_IP_LO] <= int_i; // sampled every update
			// exception fields land after mtc0 so they win
			if (exc_valid_i) begin
				status_q[STATUS_EXL] <= 1'b1;
				cause_q[CAUSE_BD] <= exc_bd_i;
				cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] <= exc_code_i;
				epc_q <= exc_epc_i;
			end else if (exc_eret_i) begin
				status_q[STATUS_EXL] <= 1'b0;
			end
			if (exc_badv_we_i) begin
				badvaddr_q <= exc_badvaddr_i;
			end
		end
	end

	function automatic word_t read_reg(input reg_addr_t addr);
		case (addr)
			CP0_BADVADDR: return badvaddr_q;
			CP0_COUNT: return count;
			CP0_COMPARE: return compare;
			CP0_STATUS: return status_q;
			CP0_CAUSE: return cause_q;
			CP0_EPC: return epc_q;
			CP0_PRID: return PRID_VAL;
			CP0_CONFIG: return CONFIG_RST;
			default: return '0; // unmapped
		endcase
	endfunction

	always_comb begin
		rdata1_o = '0;
		rdata2_o = '0;
		if (rst_n_i) begin
			rdata1_o = read_reg(raddr1_i);
			rdata2_o = read_reg(raddr2_i);
		end
	end

	assign status_o = status_q;
	assign cause_o = cause_q;
	assign epc_o = epc_q;
	assign count_o = count;

endmodule

//--- logic/cp0_top.sv
`timescale 1ns/100ps

module cp0_top (
	input logic clk,
	input logic rst_n_i,
	input logic stall_i,
	input logic we1_i,
	input logic we2_i,
	input cp0_pkg::reg_addr_t waddr1_i,
	input cp0_pkg::reg_addr_t waddr2_i,
	input cp0_pkg::word_t wdata1_i,
	input cp0_pkg::word_t wdata2_i,
	input cp0_pkg::reg_addr_t raddr1_i,
	input cp0_pkg::reg_addr_t raddr2_i,
	input cp0_pkg::exc_type_t exc_type1_i,
	input cp0_pkg::exc_type_t exc_type2_i,
	input cp0_pkg::word_t inst_addr1_i,
	input cp0_pkg::word_t inst_addr2_i,
	input logic in_dslot1_i,
	input logic in_dslot2_i,
	input cp0_pkg::word_t bad_addr1_i,
	input cp0_pkg::word_t bad_addr2_i,
	input logic [5:0] int_i,
	output cp0_pkg::word_t status_o,
	output cp0_pkg::word_t cause_o,
	output cp0_pkg::word_t epc_o,
	output cp0_pkg::word_t rdata1_o,
	output cp0_pkg::word_t rdata2_o,
	output cp0_pkg::word_t count_o,
	output logic timer_int_o
);
	import cp0_pkg::*;

	logic exc_valid;
	logic exc_eret;
	exc_code_t exc_code;
	word_t exc_epc;
	logic exc_bd;
	logic exc_badv_we;
	word_t exc_badvaddr;

	cp0_except_arb u_arb (
		.exc_type1_i(exc_type1_i),
		.exc_type2_i(exc_type2_i),
		.inst_addr1_i(inst_addr1_i),
		.inst_addr2_i(inst_addr2_i),
		.in_dslot1_i(in_dslot1_i),
		.in_dslot2_i(in_dslot2_i),
		.bad_addr1_i(bad_addr1_i),
		.bad_addr2_i(bad_addr2_i),
		.exc_valid_o(exc_valid),
		.exc_eret_o(exc_eret),
		.exc_code_o(exc_code),
		.exc_epc_o(exc_epc),
		.exc_bd_o(exc_bd),
		.exc_badv_we_o(exc_badv_we),
		.exc_badvaddr_o(exc_badvaddr)
	);

	cp0_reg u_reg (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall_i),
		.we1_i(we1_i),
		.we2_i(we2_i),
		.waddr1_i(waddr1_i),
		.waddr2_i(waddr2_i),
		.wdata1_i(wdata1_i),
		.wdata2_i(wdata2_i),
		.raddr1_i(raddr1_i),
		.raddr2_i(raddr2_i),
		.int_i(int_i),
		.exc_valid_i(exc_valid),
		.exc_eret_i(exc_eret),
		.exc_code_i(exc_code),
		.exc_epc_i(exc_epc),
		.exc_bd_i(exc_bd),
		.exc_badv_we_i(exc_badv_we),
		.exc_badvaddr_i(exc_badvaddr),
		.status_o(status_o),
		.cause_o(cause_o),
		.epc_o(epc_o),
		.rdata1_o(rdata1_o),
		.rdata2_o(rdata2_o),
		.count_o(count_o),
		.timer_int_o(timer_int_o)
	);

endmodule

//--- test/cp0_props.sv
`timescale 1ns/100ps

module cp0_props (
	input logic clk,
	input logic rst_n_i,
	input logic upd_i,
	input logic compare_we_i,
	input cp0_pkg::word_t status_i,
	input cp0_pkg::word_t cause_i,
	input cp0_pkg::word_t epc_i,
	input cp0_pkg::word_t badvaddr_i,
	input cp0_pkg::word_t count_i,
	input cp0_pkg::word_t compare_i,
	input logic timer_int_i,
	input cp0_pkg::reg_addr_t raddr1_i,
	input cp0_pkg::reg_addr_t raddr2_i,
	input cp0_pkg::word_t rdata1_i,
	input cp0_pkg::word_t rdata2_i
);
	import cp0_pkg::*;

	// a frozen cycle leaves all state alone
	frozen_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		!upd_i |=> $stable(status_i) && $stable(cause_i) && $stable(epc_i)
		&& $stable(badvaddr_i) && $stable(count_i) && $stable(compare_i)
		&& $stable(timer_int_i))
		else $error("cp0 state changed in a cycle without update");

	tint_fall_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		$fell(timer_int_i) |-> $past(!rst_n_i) || $past(compare_we_i && upd_i))
		else $error("timer interrupt dropped without a compare write");

	prid1_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		(raddr1_i == CP0_PRID) |-> (rdata1_i == PRID_VAL))
		else $error("read port 1 returned a wrong prid");

	prid2_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		(raddr2_i == CP0_PRID) |-> (rdata2_i == PRID_VAL))
		else $error("read port 2 returned a wrong prid");

endmodule

bind cp0_reg cp0_props u_props (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.upd_i(upd),
	.compare_we_i(compare_we),
	.status_i(status_q),
	.cause_i(cause_q),
	.epc_i(epc_q),
	.badvaddr_i(badvaddr_q),
	.count_i(count),
	.compare_i(compare),
	.timer_int_i(timer_int_o),
	.raddr1_i(raddr1_i),
	.raddr2_i(raddr2_i),
	.rdata1_i(rdata1_o),
	.rdata2_i(rdata2_o)
);

//--- test/cp0_tb.sv
`timescale 1ns/100ps

module cp0_tb;
	import cp0_pkg::*;

	logic clk;
	logic rst_n;
	logic stall;
	logic we1;
	logic we2;
	reg_addr_t waddr1;
	reg_addr_t waddr2;
	word_t wdata1;
	word_t wdata2;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	exc_type_t exc_type1;
	exc_type_t exc_type2;
	word_t inst_addr1;
	word_t inst_addr2;
	logic dslot1;
	logic dslot2;
	word_t bad_addr1;
	word_t bad_addr2;
	logic [5:0] int_in;
	word_t status;
	word_t cause;
	word_t epc;
	word_t rdata1;
	word_t rdata2;
	word_t count;
	logic timer_int;

	word_t m_status; // reference model state
	word_t m_cause;
	word_t m_epc;
	word_t m_badv;
	logic [32:0] m_cnt;
	word_t m_compare;
	logic m_tint;

	integer seed;
	int errors;
	int checks;
	int test_num;
	int start_err;
	reg_addr_t prev_wa;
	word_t saved_epc;
	word_t before_count;
	word_t before_status;
	word_t before_cause;
	logic [5:0] last_int;
	word_t base;
	word_t cmp;
	logic risen;
	int n;

	cp0_top dut0 (
		.clk(clk), .rst_n_i(rst_n), .stall_i(stall),
		.we1_i(we1), .we2_i(we2), .waddr1_i(waddr1), .waddr2_i(waddr2),
		.wdata1_i(wdata1), .wdata2_i(wdata2), .raddr1_i(raddr1), .raddr2_i(raddr2),
		.exc_type1_i(exc_type1), .exc_type2_i(exc_type2),
		.inst_addr1_i(inst_addr1), .inst_addr2_i(inst_addr2),
		.in_dslot1_i(dslot1), .in_dslot2_i(dslot2),
		.bad_addr1_i(bad_addr1), .bad_addr2_i(bad_addr2), .int_i(int_in),
		.status_o(status), .cause_o(cause), .epc_o(epc),
		.rdata1_o(rdata1), .rdata2_o(rdata2), .count_o(count), .timer_int_o(timer_int)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic is_exc(input exc_type_t t);
		case (t)
			EXT_INT, EXT_ADEL, EXT_ADES, EXT_SYS: return 1'b1;
			EXT_BP, EXT_RI, EXT_OV, EXT_TR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// codes follow the type number, except for interrupts
	function automatic exc_code_t code_of(input exc_type_t t);
		return (t == EXT_INT) ? 5'd0 : t[4:0];
	endfunction

	function automatic word_t model_read(input reg_addr_t a);
		case (a)
			CP0_BADVADDR: return m_badv;
			CP0_COUNT: return m_cnt[32:1];
			CP0_COMPARE: return m_compare;
			CP0_STATUS: return m_status;
			CP0_CAUSE: return m_cause;
			CP0_EPC: return m_epc;
			CP0_PRID: return PRID_VAL;
			CP0_CONFIG: return CONFIG_RST;
			default: return '0;
		endcase
	endfunction

	function reg_addr_t rand_addr();
		case ($random(seed) & 7)
			0: return CP0_COUNT;
			1: return CP0_COMPARE;
			2: return CP0_STATUS;
			3: return CP0_CAUSE;
			4: return CP0_EPC;
			5: return CP0_BADVADDR;
			6: return CP0_PRID;
			default: return $random(seed); // mostly unmapped
		endcase
	endfunction

	function exc_type_t rand_type();
		case ($random(seed) & 15)
			0: return EXT_INT;
			1: return EXT_ADEL;
			2: return EXT_ADES;
			3: return EXT_SYS;
			4: return EXT_BP;
			5: return EXT_RI;
			6: return EXT_OV;
			7: return EXT_TR;
			8: return EXT_ERET;
			9: return 32'h0000_0003; // unknown code, no event
			default: return '0;
		endcase
	endfunction

	task automatic model_reset();
		m_status = STATUS_RST;
		m_cause = '0;
		m_epc = '0;
		m_badv = '0;
		m_cnt = '0;
		m_compare = '0;
		m_tint = 1'b0;
	endtask

	task automatic model_update();
		logic w;
		reg_addr_t wa;
		word_t wd;
		logic hit;
		exc_type_t t;
		logic ds;
		word_t ia;
		word_t ba;
		if (!rst_n) begin
			model_reset();
		end else if (!(stall && (we1 || we2))) begin
			w = we1 || we2;
			wa = we2 ? waddr2 : waddr1;
			wd = we2 ? wdata2 : wdata1;
			hit = (m_compare != 0) && (m_cnt[32:1] == m_compare);
			if (w && wa == CP0_COUNT) begin
				m_cnt = {wd, ~m_cnt[0]};
			end else begin
				m_cnt = m_cnt + 33'd1;
			end
			if (w && wa == CP0_COMPARE) begin
				m_compare = wd;
				m_tint = 1'b0;
			end else if (hit) begin
				m_tint = 1'b1;
			end
			if (w && wa == CP0_STATUS) begin
				m_status = wd;
			end
			if (w && wa == CP0_CAUSE) begin
				m_cause[23:22] = wd[23:22];
				m_cause[9:8] = wd[9:8];
			end
			if (w && wa == CP0_EPC) begin
				m_epc = wd;
			end
			m_cause[15:10] = int_in;
			t = (is_exc(exc_type1) || exc_type1 == EXT_ERET) ? exc_type1 : exc_type2;
			ds = (t == exc_type1) ? dslot1 : dslot2;
			ia = (t == exc_type1) ? inst_addr1 : inst_addr2;
			ba = (t == exc_type1) ? bad_addr1 : bad_addr2;
			if (is_exc(t)) begin
				m_status[STATUS_EXL] = 1'b1;
				m_cause[CAUSE_BD] = ds;
				m_cause[6:2] = code_of(t);
				m_epc = ds ? ia - 32'd4 : ia;
				if (t == EXT_ADEL || t == EXT_ADES) begin
					m_badv = ba;
				end
			end else if (t == EXT_ERET) begin
				m_status[STATUS_EXL] = 1'b0;
			end
		end
	endtask

	task automatic check_val(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic next_fall();
		@(negedge clk);
		check_val("status_o", status, m_status);
		check_val("cause_o", cause, m_cause);
		check_val("epc_o", epc, m_epc);
		check_val("count_o", count, m_cnt[32:1]);
		check_val("timer_int_o", timer_int, m_tint);
	endtask

	task automatic clock_in();
		#1;
		check_val("rdata1_o", rdata1, rst_n ? model_read(raddr1) : '0);
		check_val("rdata2_o", rdata2, rst_n ? model_read(raddr2) : '0);
		@(posedge clk);
		model_update();
	endtask

	task automatic idle();
		stall = 1'b0;
		we1 = 1'b0;
		we2 = 1'b0;
		exc_type1 = '0;
		exc_type2 = '0;
		dslot1 = 1'b0;
		dslot2 = 1'b0;
	endtask

	task automatic report(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - start_err);
		start_err = errors;
	endtask

	initial begin
		seed = 74551;
		errors = 0;
		checks = 0;
		test_num = 0;
		start_err = 0;
		rst_n = 1'b0;
		idle();
		waddr1 = '0;
		waddr2 = '0;
		wdata1 = '0;
		wdata2 = '0;
		raddr1 = '0;
		raddr2 = '0;
		inst_addr1 = '0;
		inst_addr2 = '0;
		bad_addr1 = '0;
		bad_addr2 = '0;
		int_in = '0;
		model_reset();
		repeat (3) begin // first edge at 2 ns is already in reset
			next_fall();
			clock_in();
		end

		for (int a = 0; a < 32; a++) begin
			next_fall();
			rst_n = 1'b1;
			raddr1 = a;
			raddr2 = 31 - a;
			clock_in();
		end
		report("reset values");

		prev_wa = '0;
		repeat (60) begin
			next_fall();
			we1 = $random(seed);
			we2 = $random(seed);
			waddr1 = rand_addr();
			waddr2 = ($random(seed) & 1) ? waddr1 : rand_addr(); // force collisions
			wdata1 = $random(seed);
			wdata2 = $random(seed);
			raddr1 = prev_wa; // read back last cycle's write
			raddr2 = rand_addr();
			int_in = $random(seed);
			prev_wa = we2 ? waddr2 : waddr1;
			clock_in();
		end
		report("two-lane writes");

		repeat (80) begin
			next_fall();
			idle();
			exc_type1 = rand_type();
			exc_type2 = rand_type();
			inst_addr1 = $random(seed) & 32'hffff_fffc;
			inst_addr2 = $random(seed) & 32'hffff_fffc;
			dslot1 = $random(seed);
			dslot2 = $random(seed);
			bad_addr1 = $random(seed);
			bad_addr2 = $random(seed);
			we2 = $random(seed); // epc write racing the exception
			waddr2 = CP0_EPC;
			wdata2 = $random(seed);
			raddr1 = CP0_EPC;
			raddr2 = CP0_BADVADDR;
			int_in = $random(seed);
			clock_in();
		end
		report("exceptions");

		next_fall();
		idle();
		exc_type1 = EXT_SYS;
		inst_addr1 = 32'h0000_1230;
		we2 = 1'b1; // status write with exl clear loses to the exception
		waddr2 = CP0_STATUS;
		wdata2 = '0;
		clock_in();
		next_fall();
		check_val("status_o.exl", status[STATUS_EXL], 1'b1);
		saved_epc = 32'h0000_1230;
		idle();
		exc_type2 = EXT_ERET;
		inst_addr2 = $random(seed);
		dslot2 = 1'b1;
		clock_in();
		next_fall();
		check_val("status_o.exl", status[STATUS_EXL], 1'b0);
		check_val("epc_o", epc, saved_epc);
		idle();
		clock_in();
		report("eret");

		next_fall();
		before_count = m_cnt[32:1];
		before_status = m_status;
		before_cause = m_cause;
		idle();
		stall = 1'b1;
		we1 = 1'b1;
		waddr1 = CP0_STATUS;
		wdata1 = ~m_status;
		int_in = ~m_cause[15:10];
		clock_in();
		next_fall();
		check_val("count_o frozen", count, before_count);
		check_val("status_o frozen", status, before_status);
		check_val("cause_o frozen", cause, before_cause);
		idle();
		clock_in();
		repeat (4) begin
			next_fall();
			idle();
			stall = 1'b1;
			int_in = $random(seed);
			last_int = int_in;
			clock_in();
			next_fall();
			check_val("cause_o.ip", cause[15:10], last_int);
			idle();
			clock_in();
		end
		report("stall");

		next_fall();
		idle();
		we1 = 1'b1;
		waddr1 = CP0_COUNT;
		wdata1 = $random(seed);
		clock_in();
		next_fall();
		base = wdata1;
		idle();
		clock_in();
		next_fall();
		idle();
		clock_in();
		next_fall();
		check_val("count_o rate", count, base + 32'd1);
		cmp = $random(seed);
		cmp[8] = 1'b1; // nonzero, no wrap below
		idle();
		we2 = 1'b1;
		waddr2 = CP0_COMPARE;
		wdata2 = cmp;
		clock_in();
		next_fall();
		idle();
		we1 = 1'b1;
		waddr1 = CP0_COUNT;
		wdata1 = cmp - 32'd5;
		clock_in();
		risen = 1'b0;
		n = 0;
		while (!risen && n < 40) begin
			next_fall();
			risen = timer_int;
			idle();
			raddr1 = CP0_COUNT;
			raddr2 = CP0_COMPARE;
			clock_in();
			n++;
		end
		if (!risen) begin
			errors++;
			$display("timeout: timer interrupt did not rise within 40 cycles");
		end
		repeat (6) begin
			next_fall();
			check_val("timer_int_o held", timer_int, 1'b1);
			idle();
			clock_in();
		end
		next_fall();
		idle();
		we1 = 1'b1;
		waddr1 = CP0_COMPARE;
		wdata1 = cmp ^ 32'h8000_0000;
		clock_in();
		next_fall();
		check_val("timer_int_o cleared", timer_int, 1'b0);
		report("timer");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- cp0_top.f
logic/cp0_pkg.sv
logic/cp0_except_arb.sv
logic/cp0_timer.sv
logic/cp0_reg.sv
logic/cp0_top.sv
test/cp0_props.sv
test/cp0_tb.sv

//--- Bender.yml
package:
  name: cp0_top

sources:
  - logic/cp0_pkg.sv
  - logic/cp0_except_arb.sv
  - logic/cp0_timer.sv
  - logic/cp0_reg.sv
  - logic/cp0_top.sv
  - target: test
    files:
      - test/cp0_props.sv
      - test/cp0_tb.sv
